// ==== design/axis_defines.svh ====
`ifndef AXIS_DEFINES_SVH
`define AXIS_DEFINES_SVH

// stream geometry shared by the package, the interface and the slices

// bytes per beat, tdata is eight times this and tkeep has one bit per byte
`define AXIS_DATA_BYTE_WID 8

// sideband widths
`define AXIS_TID_WID 4
`define AXIS_TDEST_WID 4
`define AXIS_TUSER_WID 8

`endif

// ==== design/axi4s_pkg.sv ====
`default_nettype none

`include "axis_defines.svh"

package axi4s_pkg;

    // storage structure of a register slice
    typedef enum logic [1:0] {
        REG_SLICE_BYPASS,
        REG_SLICE_FORWARD,
        REG_SLICE_REVERSE,
        REG_SLICE_FULL
    } reg_slice_config_t;

    typedef logic [`AXIS_TID_WID-1:0]   tid_t;
    typedef logic [`AXIS_TDEST_WID-1:0] tdest_t;
    typedef logic [`AXIS_TUSER_WID-1:0] tuser_t;

    // cycles by which a slice delays the reset it hands downstream
    function automatic int reset_pipe_stages(input reg_slice_config_t cfg);
        case (cfg)
            REG_SLICE_BYPASS : return 0;
            default          : return 1;
        endcase
    endfunction

endpackage : axi4s_pkg

`default_nettype wire

// ==== design/axi4s_intf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_defines.svh"

interface axi4s_intf #(
    parameter type TID_T   = logic,
    parameter type TDEST_T = logic,
    parameter type TUSER_T = logic
) ();

    // clock and reset travel with the stream so each stage can delay the reset
    logic aclk;
    logic aresetn;

    logic tvalid;
    logic tready;

    logic [`AXIS_DATA_BYTE_WID*8-1:0] tdata;
    logic [`AXIS_DATA_BYTE_WID-1:0]   tkeep;
    logic                             tlast;
    TID_T                             tid;
    TDEST_T                           tdest;
    TUSER_T                           tuser;

    modport tx (
        output aclk,
        output aresetn,
        output tvalid,
        input  tready,
        output tdata,
        output tkeep,
        output tlast,
        output tid,
        output tdest,
        output tuser
    );

    modport rx (
        input  aclk,
        input  aresetn,
        input  tvalid,
        output tready,
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tid,
        input  tdest,
        input  tuser
    );

endinterface : axi4s_intf

`default_nettype wire

// ==== design/util_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module util_pipe #(
    parameter type   DATA_T      = logic,
    parameter int    PIPE_STAGES = 1,
    parameter DATA_T RESET_VALUE = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  DATA_T data_in,
    output DATA_T data_out
);

    generate
        if (PIPE_STAGES == 0) begin : g_wire
            assign data_out = data_in;
        end else begin : g_regs
            DATA_T stage_q [PIPE_STAGES];

            // tie rst_n high when the pipeline needs no reset
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < PIPE_STAGES; i++) begin
                        stage_q[i] <= RESET_VALUE;
                    end
                end else begin
                    stage_q[0] <= data_in;
                    for (int i = 1; i < PIPE_STAGES; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign data_out = stage_q[PIPE_STAGES-1];
        end
    endgenerate

endmodule : util_pipe

`default_nettype wire

// ==== design/axi4s_reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_defines.svh"

module axi4s_reg_slice #(
    parameter type TID_T   = logic,
    parameter type TDEST_T = logic,
    parameter type TUSER_T = logic,
    parameter axi4s_pkg::reg_slice_config_t CONFIG = axi4s_pkg::REG_SLICE_FULL
) (
    axi4s_intf.rx axi4s_from_tx,
    axi4s_intf.tx axi4s_to_rx
);

    // all payload fields move as one word through every storage variant
    typedef struct packed {
        logic [`AXIS_DATA_BYTE_WID*8-1:0] tdata;
        logic [`AXIS_DATA_BYTE_WID-1:0]   tkeep;
        logic                             tlast;
        TID_T                             tid;
        TDEST_T                           tdest;
        TUSER_T                           tuser;
    } beat_t;

    logic  clk;
    logic  out_rst_n;
    beat_t in_beat;
    beat_t out_beat;

    assign clk = axi4s_from_tx.aclk;
    assign axi4s_to_rx.aclk = clk;

    // assertion is asynchronous, release waits for the pipeline to fill with ones
    util_pipe #(
        .DATA_T      ( logic ),
        .PIPE_STAGES ( axi4s_pkg::reset_pipe_stages(CONFIG) ),
        .RESET_VALUE ( 1'b0 )
    ) i_util_pipe_aresetn (
        .clk      ( clk ),
        .rst_n    ( axi4s_from_tx.aresetn ),
        .data_in  ( axi4s_from_tx.aresetn ),
        .data_out ( out_rst_n )
    );

    assign axi4s_to_rx.aresetn = out_rst_n;

    assign in_beat = '{
        tdata : axi4s_from_tx.tdata,
        tkeep : axi4s_from_tx.tkeep,
        tlast : axi4s_from_tx.tlast,
        tid   : axi4s_from_tx.tid,
        tdest : axi4s_from_tx.tdest,
        tuser : axi4s_from_tx.tuser
    };

    assign axi4s_to_rx.tdata = out_beat.tdata;
    assign axi4s_to_rx.tkeep = out_beat.tkeep;
    assign axi4s_to_rx.tlast = out_beat.tlast;
    assign axi4s_to_rx.tid   = out_beat.tid;
    assign axi4s_to_rx.tdest = out_beat.tdest;
    assign axi4s_to_rx.tuser = out_beat.tuser;

    generate
        case (CONFIG)
            axi4s_pkg::REG_SLICE_BYPASS: begin : g_bypass
                assign axi4s_to_rx.tvalid   = axi4s_from_tx.tvalid;
                assign axi4s_from_tx.tready = axi4s_to_rx.tready;
                assign out_beat             = in_beat;
            end

            axi4s_pkg::REG_SLICE_FORWARD: begin : g_forward
                logic  valid_q;
                beat_t beat_q;
                logic  load;

                // the register may take a new beat whenever it empties this cycle
                assign load = !valid_q || axi4s_to_rx.tready;

                always_ff @(posedge clk or negedge out_rst_n) begin
                    if (!out_rst_n) begin
                        valid_q <= 1'b0;
                    end else if (load) begin
                        valid_q <= axi4s_from_tx.tvalid;
                    end
                end

                always_ff @(posedge clk) begin
                    if (load && axi4s_from_tx.tvalid) begin
                        beat_q <= in_beat;
                    end
                end

                assign axi4s_from_tx.tready = load;
                assign axi4s_to_rx.tvalid   = valid_q;
                assign out_beat             = beat_q;
            end

            axi4s_pkg::REG_SLICE_REVERSE: begin : g_reverse
                logic  skid_valid_q;
                logic  ready_q;
                beat_t skid_q;
                logic  in_xfer;

                assign in_xfer = axi4s_from_tx.tvalid && ready_q;

                always_ff @(posedge clk or negedge out_rst_n) begin
                    if (!out_rst_n) begin
                        skid_valid_q <= 1'b0;
                        ready_q      <= 1'b0;
                    end else if (skid_valid_q) begin
                        if (axi4s_to_rx.tready) begin
                            skid_valid_q <= 1'b0;
                            ready_q      <= 1'b1;
                        end
                    end else if (in_xfer && !axi4s_to_rx.tready) begin
                        skid_valid_q <= 1'b1;
                        ready_q      <= 1'b0;
                    end else begin
                        ready_q <= 1'b1;
                    end
                end

                always_ff @(posedge clk) begin
                    if (!skid_valid_q && in_xfer) begin
                        skid_q <= in_beat;
                    end
                end

                // while the skid entry is empty the beat flows straight through
                assign axi4s_from_tx.tready = ready_q;
                assign axi4s_to_rx.tvalid   = skid_valid_q || in_xfer;
                assign out_beat             = skid_valid_q ? skid_q : in_beat;
            end

            default: begin : g_full
                logic  main_valid_q;
                logic  spare_valid_q;
                logic  ready_q;
                beat_t main_q;
                beat_t spare_q;
                logic  in_xfer;
                logic  main_free;

                assign in_xfer   = axi4s_from_tx.tvalid && ready_q;
                assign main_free = !main_valid_q || axi4s_to_rx.tready;

                // the spare only fills when the main register is stalled
                always_ff @(posedge clk or negedge out_rst_n) begin
                    if (!out_rst_n) begin
                        main_valid_q  <= 1'b0;
                        spare_valid_q <= 1'b0;
                        ready_q       <= 1'b0;
                    end else if (main_free) begin
                        main_valid_q  <= spare_valid_q || in_xfer;
                        spare_valid_q <= 1'b0;
                        ready_q       <= 1'b1;
                    end else if (in_xfer) begin
                        spare_valid_q <= 1'b1;
                        ready_q       <= 1'b0;
                    end
                end

                always_ff @(posedge clk) begin
                    if (main_free) begin
                        main_q <= spare_valid_q ? spare_q : in_beat;
                    end else if (in_xfer) begin
                        spare_q <= in_beat;
                    end
                end

                assign axi4s_from_tx.tready = ready_q;
                assign axi4s_to_rx.tvalid   = main_valid_q;
                assign out_beat             = main_q;

                a_full_no_ready: assert property (
                    @(posedge clk) disable iff (!out_rst_n)
                    main_valid_q && spare_valid_q |-> !axi4s_from_tx.tready
                );
            end
        endcase

        // in bypass the output follows the upstream sender directly
        if (CONFIG != axi4s_pkg::REG_SLICE_BYPASS) begin : g_checks
            a_no_valid_in_reset: assert property (
                @(posedge clk) !out_rst_n |-> !axi4s_to_rx.tvalid
            );

            a_stall_stable: assert property (
                @(posedge clk) disable iff (!out_rst_n)
                axi4s_to_rx.tvalid && !axi4s_to_rx.tready
                    |=> axi4s_to_rx.tvalid && $stable(out_beat)
            );
        end
    endgenerate

endmodule : axi4s_reg_slice

`default_nettype wire

// ==== design/axi4s_slice_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_defines.svh"

module axi4s_slice_top (
    input  logic                             aclk,
    input  logic                             rst_n,

    input  logic                             s_tvalid,
    output logic                             s_tready,
    input  logic [`AXIS_DATA_BYTE_WID*8-1:0] s_tdata,
    input  logic [`AXIS_DATA_BYTE_WID-1:0]   s_tkeep,
    input  logic                             s_tlast,
    input  axi4s_pkg::tid_t                  s_tid,
    input  axi4s_pkg::tdest_t                s_tdest,
    input  axi4s_pkg::tuser_t                s_tuser,

    output logic                             m_tvalid,
    input  logic                             m_tready,
    output logic [`AXIS_DATA_BYTE_WID*8-1:0] m_tdata,
    output logic [`AXIS_DATA_BYTE_WID-1:0]   m_tkeep,
    output logic                             m_tlast,
    output axi4s_pkg::tid_t                  m_tid,
    output axi4s_pkg::tdest_t                m_tdest,
    output axi4s_pkg::tuser_t                m_tuser,
    output logic                             m_rst_n
);

    axi4s_intf #(
        .TID_T   ( axi4s_pkg::tid_t ),
        .TDEST_T ( axi4s_pkg::tdest_t ),
        .TUSER_T ( axi4s_pkg::tuser_t )
    ) i_axis_in ();

    axi4s_intf #(
        .TID_T   ( axi4s_pkg::tid_t ),
        .TDEST_T ( axi4s_pkg::tdest_t ),
        .TUSER_T ( axi4s_pkg::tuser_t )
    ) i_axis_mid ();

    axi4s_intf #(
        .TID_T   ( axi4s_pkg::tid_t ),
        .TDEST_T ( axi4s_pkg::tdest_t ),
        .TUSER_T ( axi4s_pkg::tuser_t )
    ) i_axis_out ();

    assign i_axis_in.aclk    = aclk;
    assign i_axis_in.aresetn = rst_n;
    assign i_axis_in.tvalid  = s_tvalid;
    assign i_axis_in.tdata   = s_tdata;
    assign i_axis_in.tkeep   = s_tkeep;
    assign i_axis_in.tlast   = s_tlast;
    assign i_axis_in.tid     = s_tid;
    assign i_axis_in.tdest   = s_tdest;
    assign i_axis_in.tuser   = s_tuser;
    assign s_tready          = i_axis_in.tready;

    // ingress decouples both directions, egress only retimes valid and payload
    axi4s_reg_slice #(
        .TID_T   ( axi4s_pkg::tid_t ),
        .TDEST_T ( axi4s_pkg::tdest_t ),
        .TUSER_T ( axi4s_pkg::tuser_t ),
        .CONFIG  ( axi4s_pkg::REG_SLICE_FULL )
    ) i_ingress_slice (
        .axi4s_from_tx ( i_axis_in ),
        .axi4s_to_rx   ( i_axis_mid )
    );

    axi4s_reg_slice #(
        .TID_T   ( axi4s_pkg::tid_t ),
        .TDEST_T ( axi4s_pkg::tdest_t ),
        .TUSER_T ( axi4s_pkg::tuser_t ),
        .CONFIG  ( axi4s_pkg::REG_SLICE_FORWARD )
    ) i_egress_slice (
        .axi4s_from_tx ( i_axis_mid ),
        .axi4s_to_rx   ( i_axis_out )
    );

    assign m_tvalid          = i_axis_out.tvalid;
    assign i_axis_out.tready = m_tready;
    assign m_tdata           = i_axis_out.tdata;
    assign m_tkeep           = i_axis_out.tkeep;
    assign m_tlast           = i_axis_out.tlast;
    assign m_tid             = i_axis_out.tid;
    assign m_tdest           = i_axis_out.tdest;
    assign m_tuser           = i_axis_out.tuser;
    assign m_rst_n           = i_axis_out.aresetn;

endmodule : axi4s_slice_top

`default_nettype wire

// ==== verification/tb_axi4s_slice_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_defines.svh"

module tb_axi4s_slice_top;

    localparam int DATA_W    = `AXIS_DATA_BYTE_WID * 8;
    localparam int KEEP_W    = `AXIS_DATA_BYTE_WID;
    localparam int DEST_LSB  = `AXIS_TUSER_WID;
    localparam int ID_LSB    = DEST_LSB + `AXIS_TDEST_WID;
    localparam int LAST_LSB  = ID_LSB + `AXIS_TID_WID;
    localparam int KEEP_LSB  = LAST_LSB + 4;
    localparam int DATA_LSB  = KEEP_LSB + KEEP_W;
    localparam int WORD_W    = DATA_LSB + DATA_W;
    localparam int NUM_BEATS = 24;
    localparam int LAT_BEATS = 8;
    // the full slice and the forward slice each hold the reset back one edge
    localparam int M_RST_EDGES = 2;
    // ingress ready is registered and rises one edge after the ingress reset releases
    localparam int READY_EDGES = 2;
    // two skid entries in the full slice plus the forward register
    localparam int SLICE_DEPTH = 3;
    localparam int WATCHDOG_CYCLES = 4 * (NUM_BEATS + 20);

    logic                     aclk = 1'b0;
    logic                     rst_n;
    logic                     s_tvalid;
    logic                     s_tready;
    logic [DATA_W-1:0]        s_tdata;
    logic [KEEP_W-1:0]        s_tkeep;
    logic                     s_tlast;
    axi4s_pkg::tid_t          s_tid;
    axi4s_pkg::tdest_t        s_tdest;
    axi4s_pkg::tuser_t        s_tuser;
    logic                     m_tvalid;
    logic                     m_tready;
    logic [DATA_W-1:0]        m_tdata;
    logic [KEEP_W-1:0]        m_tkeep;
    logic                     m_tlast;
    axi4s_pkg::tid_t          m_tid;
    axi4s_pkg::tdest_t        m_tdest;
    axi4s_pkg::tuser_t        m_tuser;
    logic                     m_rst_n;

    logic [WORD_W-1:0]        beats    [NUM_BEATS];
    logic [DATA_W-1:0]        exp_data [NUM_BEATS];
    logic [KEEP_W-1:0]        exp_keep [NUM_BEATS];
    logic                     exp_last [NUM_BEATS];
    axi4s_pkg::tid_t          exp_id   [NUM_BEATS];
    axi4s_pkg::tdest_t        exp_dest [NUM_BEATS];
    axi4s_pkg::tuser_t        exp_user [NUM_BEATS];
    int                       in_edge  [NUM_BEATS];
    int                       out_edge [NUM_BEATS];

    logic [15:0]              lfsr;
    int                       edge_cnt;
    int                       in_idx;
    int                       out_idx;
    logic                     in_pending;
    logic                     held_valid;
    string                    test_name;
    int                       beat_errs;
    int                       side_errs;
    int                       reset_errs;
    int                       other_errs;

    axi4s_slice_top i_dut (
        .aclk     ( aclk ),
        .rst_n    ( rst_n ),
        .s_tvalid ( s_tvalid ),
        .s_tready ( s_tready ),
        .s_tdata  ( s_tdata ),
        .s_tkeep  ( s_tkeep ),
        .s_tlast  ( s_tlast ),
        .s_tid    ( s_tid ),
        .s_tdest  ( s_tdest ),
        .s_tuser  ( s_tuser ),
        .m_tvalid ( m_tvalid ),
        .m_tready ( m_tready ),
        .m_tdata  ( m_tdata ),
        .m_tkeep  ( m_tkeep ),
        .m_tlast  ( m_tlast ),
        .m_tid    ( m_tid ),
        .m_tdest  ( m_tdest ),
        .m_tuser  ( m_tuser ),
        .m_rst_n  ( m_rst_n )
    );

    always #20 aclk = ~aclk;

    // Galois LFSR whose shifted-out bit is the random bit
    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hB400 : 16'h0000);
        return out;
    endfunction

    task automatic compare_beat(
        input string             name,
        input logic [DATA_W-1:0] exp_d,
        input logic [DATA_W-1:0] act_d,
        input logic [KEEP_W-1:0] exp_k,
        input logic [KEEP_W-1:0] act_k,
        input logic              exp_l,
        input logic              act_l
    );
        if (act_d !== exp_d) begin
            $display("Fail %s: tdata expected %h, actual %h", name, exp_d, act_d);
            beat_errs++;
        end
        if (act_k !== exp_k) begin
            $display("Fail %s: tkeep expected %h, actual %h", name, exp_k, act_k);
            beat_errs++;
        end
        if (act_l !== exp_l) begin
            $display("Fail %s: tlast expected %b, actual %b", name, exp_l, act_l);
            beat_errs++;
        end
    endtask

    task automatic compare_side(
        input string             name,
        input axi4s_pkg::tid_t   exp_i,
        input axi4s_pkg::tid_t   act_i,
        input axi4s_pkg::tdest_t exp_d,
        input axi4s_pkg::tdest_t act_d,
        input axi4s_pkg::tuser_t exp_u,
        input axi4s_pkg::tuser_t act_u
    );
        if (act_i !== exp_i) begin
            $display("Fail %s: tid expected %h, actual %h", name, exp_i, act_i);
            side_errs++;
        end
        if (act_d !== exp_d) begin
            $display("Fail %s: tdest expected %h, actual %h", name, exp_d, act_d);
            side_errs++;
        end
        if (act_u !== exp_u) begin
            $display("Fail %s: tuser expected %h, actual %h", name, exp_u, act_u);
            side_errs++;
        end
    endtask

    task automatic compare_reset(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Fail %s: expected %b, actual %b", name, exp_v, act_v);
            reset_errs++;
        end
    endtask

    // one clock cycle of stimulus with the checks made while nothing on the bus moves
    task automatic step(input logic offer, input logic take);
        @(negedge aclk);
        edge_cnt++;
        if (!in_pending) begin
            s_tvalid = offer && (in_idx < NUM_BEATS);
            if (in_idx < NUM_BEATS) begin
                s_tdata = exp_data[in_idx];
                s_tkeep = exp_keep[in_idx];
                s_tlast = exp_last[in_idx];
                s_tid   = exp_id[in_idx];
                s_tdest = exp_dest[in_idx];
                s_tuser = exp_user[in_idx];
            end
        end
        m_tready = take;
        if (s_tvalid && s_tready) begin
            in_edge[in_idx] = edge_cnt;
            in_idx++;
        end
        in_pending = s_tvalid && !s_tready;
        if (held_valid && !m_tvalid) begin
            $display("%s: m_tvalid dropped before its beat was taken", test_name);
            other_errs++;
        end
        if (m_tvalid && out_idx >= NUM_BEATS) begin
            $display("%s: m_tvalid high after every beat came out", test_name);
            other_errs++;
        end else if (m_tvalid) begin
            // a stalled beat is compared again every cycle and so must hold still
            compare_beat(test_name, exp_data[out_idx], m_tdata, exp_keep[out_idx], m_tkeep,
                         exp_last[out_idx], m_tlast);
            compare_side(test_name, exp_id[out_idx], m_tid, exp_dest[out_idx], m_tdest,
                         exp_user[out_idx], m_tuser);
            if (m_tready) begin
                out_edge[out_idx] = edge_cnt;
                out_idx++;
            end
        end
        held_valid = m_tvalid && !m_tready;
    endtask

    initial begin
        int   accepted_before;
        logic offer;
        logic take;
        rst_n      = 1'b0;
        s_tvalid   = 1'b0;
        s_tdata    = '0;
        s_tkeep    = '0;
        s_tlast    = 1'b0;
        s_tid      = '0;
        s_tdest    = '0;
        s_tuser    = '0;
        m_tready   = 1'b0;
        lfsr       = 16'd78;
        edge_cnt   = 0;
        in_idx     = 0;
        out_idx    = 0;
        in_pending = 1'b0;
        held_valid = 1'b0;
        beat_errs  = 0;
        side_errs  = 0;
        reset_errs = 0;
        other_errs = 0;
        $readmemh("verification/axi4s_testdata.txt", beats);
        for (int i = 0; i < NUM_BEATS; i++) begin
            exp_data[i] = beats[i][DATA_LSB +: DATA_W];
            exp_keep[i] = beats[i][KEEP_LSB +: KEEP_W];
            exp_last[i] = beats[i][LAST_LSB];
            exp_id[i]   = beats[i][ID_LSB +: `AXIS_TID_WID];
            exp_dest[i] = beats[i][DEST_LSB +: `AXIS_TDEST_WID];
            exp_user[i] = beats[i][0 +: `AXIS_TUSER_WID];
        end

        repeat (2) begin
            @(negedge aclk);
            compare_reset("reset m_rst_n", 1'b0, m_rst_n);
            compare_reset("reset s_tready", 1'b0, s_tready);
            compare_reset("reset m_tvalid", 1'b0, m_tvalid);
        end
        rst_n = 1'b1;
        for (int n = 1; n <= 3; n++) begin
            @(negedge aclk);
            compare_reset("release m_rst_n", n >= M_RST_EDGES, m_rst_n);
            compare_reset("release s_tready", n >= READY_EDGES, s_tready);
            compare_reset("release m_tvalid", 1'b0, m_tvalid);
        end

        test_name = "latency";
        while (in_idx < LAT_BEATS) step(1'b1, 1'b1);
        while (out_idx < LAT_BEATS) step(1'b0, 1'b1);
        for (int i = 0; i < LAT_BEATS; i++) begin
            if (out_edge[i] != in_edge[i] + 2) begin
                $display("Fail latency: beat %0d expected at edge %0d, actual edge %0d",
                         i, in_edge[i] + 2, out_edge[i]);
                other_errs++;
            end
            if (i > 0 && out_edge[i] != out_edge[i-1] + 1) begin
                $display("Fail throughput: beat %0d expected at edge %0d, actual edge %0d",
                         i, out_edge[i-1] + 1, out_edge[i]);
                other_errs++;
            end
        end

        test_name = "backpressure";
        accepted_before = in_idx;
        repeat (2 * SLICE_DEPTH) step(1'b1, 1'b0);
        if (in_idx - accepted_before > SLICE_DEPTH) begin
            $display("Fail backpressure: expected at most %0d beats taken, actual %0d",
                     SLICE_DEPTH, in_idx - accepted_before);
            other_errs++;
        end
        if (s_tready !== 1'b0) begin
            $display("Fail backpressure: s_tready expected 0, actual %b", s_tready);
            other_errs++;
        end

        test_name = "random stalls";
        while (out_idx < NUM_BEATS) begin
            offer = rand_bit();
            take  = rand_bit();
            step(offer, take);
        end
        test_name = "idle";
        repeat (4) step(1'b0, 1'b1);
        if (in_idx != NUM_BEATS) begin
            $display("Fail beat count: expected %0d beats taken, actual %0d", NUM_BEATS, in_idx);
            other_errs++;
        end

        // the reset must reach m_rst_n without waiting for a clock edge
        @(negedge aclk);
        rst_n = 1'b0;
        #1;
        compare_reset("async m_rst_n", 1'b0, m_rst_n);
        compare_reset("async s_tready", 1'b0, s_tready);

        $display("errors: beat %0d, sideband %0d, reset %0d, other %0d",
                 beat_errs, side_errs, reset_errs, other_errs);
        if (beat_errs + side_errs + reset_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule : tb_axi4s_slice_top

`default_nettype wire

// ==== verification/axi4s_testdata.txt ====
// one beat per line: tdata(16 hex) _ tkeep(2) _ tlast(1) _ tid(1) _ tdest(1) _ tuser(2)
// the same beats in the same order are expected at the output
0011223344556677_ff_0_1_2_10
8899aabbccddeeff_ff_0_1_2_11
0123456789abcdef_ff_0_1_2_12
fedcba9876543210_0f_1_1_2_13
a5a5a5a5a5a5a5a5_ff_1_2_5_20
1111111111111111_ff_0_3_7_30
2222222222222222_ff_0_3_7_31
3333333333333333_3f_1_3_7_32
deadbeefcafef00d_ff_0_4_1_40
0f1e2d3c4b5a6978_ff_0_4_1_41
8796a5b4c3d2e1f0_ff_0_4_1_42
5555aaaa5555aaaa_ff_0_4_1_43
00000000000000ff_01_1_4_1_44
7766554433221100_ff_0_5_9_50
ffeeddccbbaa9988_07_1_5_9_51
13579bdf02468ace_ff_1_6_3_60
c0ffee0012345678_ff_0_7_e_70
9abcdef012345678_ff_0_7_e_71
0102030405060708_ff_0_7_e_72
1020304050607080_1f_1_7_e_73
ffffffffffffffff_ff_0_8_f_80
0000000000000000_ff_0_8_f_81
8000000000000001_ff_0_8_f_82
7ffffffffffffffe_03_1_8_f_83

// ==== list.f ====
+incdir+design
design/axi4s_pkg.sv
design/axi4s_intf.sv
design/util_pipe.sv
design/axi4s_reg_slice.sv
design/axi4s_slice_top.sv
verification/tb_axi4s_slice_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into sim.log and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module tb_axi4s_slice_top -o sim_axi4s \
    && ./obj_dir/sim_axi4s > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
